// File: design/cpu_pkg.sv
//--------------------------------------
// cpu package: shared types for decode and execute
// opcodes, alu/compare encodings, pipeline bundles
//--------------------------------------
package cpu_pkg;

	typedef logic [31:0] word_t;		// data, pc or instruction
	typedef logic [4:0]  reg_addr_t;	// gpr index

	//--------------------------------------
	// major opcode, insn[31:26]
	//--------------------------------------
	typedef enum logic [5:0] {
		OP_NOP  = 6'h00,
		OP_ADD  = 6'h01,
		OP_SUB  = 6'h02,
		OP_AND  = 6'h03,
		OP_OR   = 6'h04,
		OP_XOR  = 6'h05,
		OP_SLL  = 6'h06,	// shift by rt[4:0]
		OP_SRL  = 6'h07,
		OP_ADDI = 6'h08,	// rs + sext(imm16)
		OP_BEQ  = 6'h10,	// compares rs with rd
		OP_BNE  = 6'h11,
		OP_BLT  = 6'h12,	// signed
		OP_HALT = 6'h3f
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_NOP = 4'h0,
		ALU_ADD = 4'h1,
		ALU_SUB = 4'h2,
		ALU_AND = 4'h3,
		ALU_OR  = 4'h4,
		ALU_XOR = 4'h5,
		ALU_SLL = 4'h6,
		ALU_SRL = 4'h7
	} alu_op_e;

	typedef enum logic [2:0] {
		CMP_NONE = 3'h0,
		CMP_EQ   = 3'h1,
		CMP_NE   = 3'h2,
		CMP_LT   = 3'h3	// signed less than
	} cmp_op_e;

	//--------------------------------------
	// pipeline bundles
	//--------------------------------------
	typedef struct packed {
		logic  valid;
		word_t pc;
		word_t insn;
	} fetch_t;

	typedef struct packed {
		logic      en;			// stage holds a real instruction
		word_t     pc;
		alu_op_e   alu_op;
		cmp_op_e   cmp_op;
		word_t     alu_in_0;
		word_t     alu_in_1;
		word_t     cmp_in_0;
		word_t     cmp_in_1;
		word_t     br_offset;	// sign-extended imm16
		logic      gpr_we;
		reg_addr_t dst_addr;
		logic      is_halt;
	} id_bundle_t;

	typedef struct packed {
		logic      valid;
		reg_addr_t dst_addr;
		word_t     data;
	} wb_t;

	typedef struct packed {
		logic  valid;
		word_t target;
	} redirect_t;

endpackage

// File: design/gpr_file.sv
//--------------------------------------
// general register file, 32 x 32
// two async read ports, one write port, r0 reads zero
//--------------------------------------
`timescale 1ns/1ns

module gpr_file (
	input  logic               clk,
	input  logic               arst_n,
	input  cpu_pkg::reg_addr_t rd_addr_a,
	input  cpu_pkg::reg_addr_t rd_addr_b,
	output cpu_pkg::word_t     rd_data_a,
	output cpu_pkg::word_t     rd_data_b,
	input  cpu_pkg::wb_t       wb
);
	import cpu_pkg::*;

	word_t regs [32];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.valid && (wb.dst_addr != '0)) begin
			regs[wb.dst_addr] <= wb.data;
		end
	end

	// the result on the write port is already architectural,
	// so a read in the same cycle sees it
	function automatic word_t read_port(reg_addr_t addr);
		word_t data;
		if (addr == '0) begin
			data = '0;							// r0 hardwired
		end else if (wb.valid && (wb.dst_addr == addr)) begin
			data = wb.data;						// write-through
		end else begin
			data = regs[addr];
		end
		return data;
	endfunction

	always_comb rd_data_a = read_port(rd_addr_a);
	always_comb rd_data_b = read_port(rd_addr_b);

endmodule

// File: design/decoder.sv
//--------------------------------------
// instruction decoder
// operand read, forwarding select, decoded bundle
//--------------------------------------
`timescale 1ns/1ns

module decoder (
	input  cpu_pkg::fetch_t     fetch,
	output cpu_pkg::reg_addr_t  rd_addr_a,
	output cpu_pkg::reg_addr_t  rd_addr_b,
	input  cpu_pkg::word_t      rd_data_a,
	input  cpu_pkg::word_t      rd_data_b,
	input  cpu_pkg::word_t      ex_value,
	input  logic                fwd_a,
	input  logic                fwd_b,
	output logic                src_a_used,
	output logic                src_b_used,
	output cpu_pkg::id_bundle_t bundle
);
	import cpu_pkg::*;

	opcode_e   opcode;
	reg_addr_t rd;
	reg_addr_t rs;
	reg_addr_t rt;
	word_t     imm_sext;
	word_t     val_a;
	word_t     val_b;
	logic      is_branch;

	//--------------------------------------
	// field extraction
	//--------------------------------------
	assign opcode   = opcode_e'(fetch.insn[31:26]);
	assign rd       = fetch.insn[25:21];
	assign rs       = fetch.insn[20:16];
	assign rt       = fetch.insn[15:11];
	assign imm_sext = {{16{fetch.insn[15]}}, fetch.insn[15:0]};

	assign is_branch = (opcode == OP_BEQ) || (opcode == OP_BNE) || (opcode == OP_BLT);

	assign rd_addr_a = rs;
	assign rd_addr_b = is_branch ? rd : rt;	// branches read rd as 2nd operand

	// result still in EX beats the register file
	assign val_a = fwd_a ? ex_value : rd_data_a;
	assign val_b = fwd_b ? ex_value : rd_data_b;

	always_comb begin
		bundle.en        = fetch.valid;
		bundle.pc        = fetch.pc;
		bundle.alu_op    = ALU_NOP;
		bundle.cmp_op    = CMP_NONE;
		bundle.alu_in_0  = val_a;
		bundle.alu_in_1  = val_b;
		bundle.cmp_in_0  = val_a;
		bundle.cmp_in_1  = val_b;
		bundle.br_offset = imm_sext;
		bundle.gpr_we    = 1'b0;
		bundle.dst_addr  = rd;
		bundle.is_halt   = 1'b0;
		src_a_used       = 1'b0;
		src_b_used       = 1'b0;

		case (opcode)
			OP_ADD:  bundle.alu_op = ALU_ADD;
			OP_SUB:  bundle.alu_op = ALU_SUB;
			OP_AND:  bundle.alu_op = ALU_AND;
			OP_OR:   bundle.alu_op = ALU_OR;
			OP_XOR:  bundle.alu_op = ALU_XOR;
			OP_SLL:  bundle.alu_op = ALU_SLL;
			OP_SRL:  bundle.alu_op = ALU_SRL;
			OP_ADDI: bundle.alu_op = ALU_ADD;
			OP_BEQ:  bundle.cmp_op = CMP_EQ;
			OP_BNE:  bundle.cmp_op = CMP_NE;
			OP_BLT:  bundle.cmp_op = CMP_LT;
			OP_HALT: bundle.is_halt = 1'b1;
			default: ;							// nop and unknown opcodes
		endcase

		// operand usage and write enable by format
		if (bundle.alu_op != ALU_NOP) begin
			bundle.gpr_we = 1'b1;
			src_a_used    = 1'b1;
			if (opcode == OP_ADDI) begin
				bundle.alu_in_1 = imm_sext;	// I-form
			end else begin
				src_b_used = 1'b1;
			end
		end
		if (is_branch) begin
			src_a_used = 1'b1;
			src_b_used = 1'b1;
		end
	end

endmodule

// File: design/id_reg.sv
//--------------------------------------
// ID/EX stage register
// stall holds, flush loads a bubble
//--------------------------------------
`timescale 1ns/1ns

module id_reg (
	input  logic                clk,
	input  logic                arst_n,
	input  cpu_pkg::id_bundle_t bundle,
	input  logic                stall,
	input  logic                flush,
	output cpu_pkg::id_bundle_t id_bundle
);
	import cpu_pkg::*;

	// empty slot: no write, no compare, not a halt
	localparam id_bundle_t BUBBLE = '{
		en:        1'b0,
		pc:        '0,
		alu_op:    ALU_NOP,
		cmp_op:    CMP_NONE,
		alu_in_0:  '0,
		alu_in_1:  '0,
		cmp_in_0:  '0,
		cmp_in_1:  '0,
		br_offset: '0,
		gpr_we:    1'b0,
		dst_addr:  '0,
		is_halt:   1'b0
	};

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			id_bundle <= BUBBLE;
		end else if (!stall) begin
			if (flush) begin
				id_bundle <= BUBBLE;	// squash wrong-path instruction
			end else begin
				id_bundle <= bundle;
			end
		end
	end

	//--------------------------------------
	// checks
	//--------------------------------------
	// pipe_ctrl must never freeze and squash the stage at once
	a_no_stall_flush: assert property (
		@(posedge clk) disable iff (!arst_n) !(stall && flush)
	) else $error("id_reg: stall and flush both high");

endmodule

// File: design/ex_unit.sv
//--------------------------------------
// execute unit: alu, compare, branch target
// registered writeback and redirect
//--------------------------------------
`timescale 1ns/1ns

module ex_unit (
	input  logic                clk,
	input  logic                arst_n,
	input  cpu_pkg::id_bundle_t id_bundle,
	input  logic                hold,
	output cpu_pkg::word_t      ex_value,
	output logic                br_taken,
	output logic                is_halt,
	output cpu_pkg::wb_t        wb,
	output cpu_pkg::redirect_t  redirect
);
	import cpu_pkg::*;

	word_t     alu_out;
	logic      cmp_true;
	word_t     br_target;
	logic      wb_valid;
	reg_addr_t wb_dst;
	word_t     wb_data;
	logic      rdir_valid;
	word_t     rdir_target;

	//--------------------------------------
	// combinational execute
	//--------------------------------------
	always_comb begin
		case (id_bundle.alu_op)
			ALU_ADD: alu_out = id_bundle.alu_in_0 + id_bundle.alu_in_1;
			ALU_SUB: alu_out = id_bundle.alu_in_0 - id_bundle.alu_in_1;
			ALU_AND: alu_out = id_bundle.alu_in_0 & id_bundle.alu_in_1;
			ALU_OR:  alu_out = id_bundle.alu_in_0 | id_bundle.alu_in_1;
			ALU_XOR: alu_out = id_bundle.alu_in_0 ^ id_bundle.alu_in_1;
			ALU_SLL: alu_out = id_bundle.alu_in_0 << id_bundle.alu_in_1[4:0];
			ALU_SRL: alu_out = id_bundle.alu_in_0 >> id_bundle.alu_in_1[4:0];
			default: alu_out = '0;
		endcase
	end

	always_comb begin
		case (id_bundle.cmp_op)
			CMP_EQ:  cmp_true = (id_bundle.cmp_in_0 == id_bundle.cmp_in_1);
			CMP_NE:  cmp_true = (id_bundle.cmp_in_0 != id_bundle.cmp_in_1);
			CMP_LT:  cmp_true = ($signed(id_bundle.cmp_in_0) < $signed(id_bundle.cmp_in_1));
			default: cmp_true = 1'b0;
		endcase
	end

	assign br_target = id_bundle.pc + id_bundle.br_offset;
	assign br_taken  = id_bundle.en && (id_bundle.cmp_op != CMP_NONE) && cmp_true;
	assign is_halt   = id_bundle.en && id_bundle.is_halt;
	assign ex_value  = alu_out;		// forwarding source

	//--------------------------------------
	// output registers, frozen by hold
	//--------------------------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb_valid   <= 1'b0;
			rdir_valid <= 1'b0;
		end else if (!hold) begin
			wb_valid   <= id_bundle.en && id_bundle.gpr_we;
			rdir_valid <= br_taken;
		end
	end

	always_ff @(posedge clk) begin
		if (!hold) begin
			wb_dst      <= id_bundle.dst_addr;
			wb_data     <= alu_out;
			rdir_target <= br_target;
		end
	end

	assign wb       = '{valid: wb_valid, dst_addr: wb_dst, data: wb_data};
	assign redirect = '{valid: rdir_valid, target: rdir_target};

	// a taken branch never writes back
	a_redirect_no_wb: assert property (
		@(posedge clk) disable iff (!arst_n) redirect.valid |-> !wb.valid
	) else $error("ex_unit: redirect issued together with writeback");

endmodule

// File: design/pipe_ctrl.sv
//--------------------------------------
// pipeline control: forwarding, stall, flush
// and the run/halt state machine
//--------------------------------------
`timescale 1ns/1ns

module pipe_ctrl (
	input  logic               clk,
	input  logic               arst_n,
	input  cpu_pkg::reg_addr_t src_a,
	input  cpu_pkg::reg_addr_t src_b,
	input  logic               src_a_used,
	input  logic               src_b_used,
	input  cpu_pkg::reg_addr_t ex_dst,
	input  logic               ex_we,
	input  logic               ex_en,
	input  logic               br_taken,
	input  logic               is_halt,
	input  logic               ex_hold,
	output logic               fwd_a,
	output logic               fwd_b,
	output logic               stall,
	output logic               flush,
	output logic               hold,
	output logic               in_ready,
	output logic               halted
);
	import cpu_pkg::*;

	typedef enum logic {
		ST_RUN,
		ST_HALTED
	} state_e;

	state_e state;
	state_e state_nxt;
	logic   ex_writes;

	//--------------------------------------
	// hazard detection
	//--------------------------------------
	assign ex_writes = ex_en && ex_we && (ex_dst != '0);	// r0 never forwards
	assign fwd_a     = ex_writes && src_a_used && (ex_dst == src_a);
	assign fwd_b     = ex_writes && src_b_used && (ex_dst == src_b);

	assign hold     = ex_hold;
	assign stall    = ex_hold || (state != ST_RUN);
	assign in_ready = !stall;
	assign halted   = (state == ST_HALTED);

	// the instruction accepted behind a taken branch is wrong-path;
	// behind a halt it must not execute either
	assign flush = (br_taken || is_halt) && !stall;

	always_comb begin
		state_nxt = state;
		case (state)
			ST_RUN:    if (is_halt && !ex_hold) state_nxt = ST_HALTED;
			ST_HALTED: state_nxt = ST_HALTED;	// only reset leaves
			default:   state_nxt = ST_RUN;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= ST_RUN;
		end else begin
			state <= state_nxt;
		end
	end

	// halt squashes the slot behind it, so EX stays empty once halted
	a_halt_empties_ex: assert property (
		@(posedge clk) disable iff (!arst_n) halted |-> !ex_en
	) else $error("pipe_ctrl: instruction in EX while halted");

endmodule

// File: design/id_ex_core.sv
//--------------------------------------
// decode/execute slice top level
//--------------------------------------
`timescale 1ns/1ns

module id_ex_core (
	input  logic               clk,
	input  logic               arst_n,
	input  cpu_pkg::fetch_t    fetch_in,
	input  logic               ex_hold,
	output logic               in_ready,
	output cpu_pkg::wb_t       wb_out,
	output cpu_pkg::redirect_t redirect_out,
	output logic               halted
);
	import cpu_pkg::*;

	reg_addr_t  rd_addr_a;
	reg_addr_t  rd_addr_b;
	word_t      rd_data_a;
	word_t      rd_data_b;
	word_t      ex_value;
	logic       src_a_used;
	logic       src_b_used;
	logic       fwd_a;
	logic       fwd_b;
	id_bundle_t dec_bundle;	// decoder -> stage register
	id_bundle_t ex_bundle;	// stage register -> execute
	logic       br_taken;
	logic       ex_is_halt;
	logic       stall;
	logic       flush;
	logic       hold;

	gpr_file u_gpr_file (
		.clk       (clk),
		.arst_n    (arst_n),
		.rd_addr_a (rd_addr_a),
		.rd_addr_b (rd_addr_b),
		.rd_data_a (rd_data_a),
		.rd_data_b (rd_data_b),
		.wb        (wb_out)
	);

	decoder u_decoder (
		.fetch      (fetch_in),
		.rd_addr_a  (rd_addr_a),
		.rd_addr_b  (rd_addr_b),
		.rd_data_a  (rd_data_a),
		.rd_data_b  (rd_data_b),
		.ex_value   (ex_value),
		.fwd_a      (fwd_a),
		.fwd_b      (fwd_b),
		.src_a_used (src_a_used),
		.src_b_used (src_b_used),
		.bundle     (dec_bundle)
	);

	id_reg u_id_reg (
		.clk       (clk),
		.arst_n    (arst_n),
		.bundle    (dec_bundle),
		.stall     (stall),
		.flush     (flush),
		.id_bundle (ex_bundle)
	);

	ex_unit u_ex_unit (
		.clk       (clk),
		.arst_n    (arst_n),
		.id_bundle (ex_bundle),
		.hold      (hold),
		.ex_value  (ex_value),
		.br_taken  (br_taken),
		.is_halt   (ex_is_halt),
		.wb        (wb_out),
		.redirect  (redirect_out)
	);

	pipe_ctrl u_pipe_ctrl (
		.clk        (clk),
		.arst_n     (arst_n),
		.src_a      (rd_addr_a),
		.src_b      (rd_addr_b),
		.src_a_used (src_a_used),
		.src_b_used (src_b_used),
		.ex_dst     (ex_bundle.dst_addr),
		.ex_we      (ex_bundle.gpr_we),
		.ex_en      (ex_bundle.en),
		.br_taken   (br_taken),
		.is_halt    (ex_is_halt),
		.ex_hold    (ex_hold),
		.fwd_a      (fwd_a),
		.fwd_b      (fwd_b),
		.stall      (stall),
		.flush      (flush),
		.hold       (hold),
		.in_ready   (in_ready),
		.halted     (halted)
	);

endmodule

// File: testbench/tb_checker.sv
//--------------------------------------
// checker: architectural model of the accepted stream,
// compares writeback, redirect and halt behavior
//--------------------------------------
`timescale 1ns/1ns

module tb_checker (
	input  logic               clk,
	input  logic               arst_n,
	input  cpu_pkg::fetch_t    fetch_in,
	input  logic               ex_hold,
	input  logic               in_ready,
	input  cpu_pkg::wb_t       wb_out,
	input  cpu_pkg::redirect_t redirect_out,
	input  logic               halted,
	output int                 errors,
	output logic               done
);
	import cpu_pkg::*;

	typedef struct packed {
		logic      is_rdir;
		reg_addr_t dst;
		word_t     val;		// data or target
	} exp_t;

	exp_t  exp_q [$];
	word_t model_regs [32];
	logic  skip_next;	// taken branch or halt still in EX
	logic  halt_seen;
	logic  upd_prev;
	int    wb_chk, wb_err, rd_chk, rd_err, dropped, halt_err, post_halt;

	assign errors = wb_err + rd_err + halt_err;

	task automatic check_event(logic is_rdir, reg_addr_t dst, word_t val);
		exp_t e;
		if (is_rdir) rd_chk++;
		else wb_chk++;
		if (exp_q.size() == 0) begin
			$display("unexpected %s with nothing pending", is_rdir ? "redirect" : "writeback");
			if (is_rdir) rd_err++;
			else wb_err++;
		end else begin
			e = exp_q.pop_front();
			if (e.is_rdir != is_rdir) begin
				$display("result out of order, got %s", is_rdir ? "redirect" : "writeback");
				if (is_rdir) rd_err++;
				else wb_err++;
			end else if (is_rdir && e.val != val) begin
				$display("MISMATCH redirect_out.target exp %h got %h", e.val, val);
				rd_err++;
			end else if (!is_rdir && (e.dst != dst || e.val != val)) begin
				$display("MISMATCH wb_out exp %h:%h got %h:%h", e.dst, e.val, dst, val);
				wb_err++;
			end
		end
	endtask

	task automatic run_model(word_t pc, word_t insn);
		logic [5:0] op;
		reg_addr_t  rd;
		word_t      a, b, c, imm, res;
		logic       writes;
		logic       taken;
		op     = insn[31:26];
		rd     = insn[25:21];
		a      = model_regs[insn[20:16]];
		b      = model_regs[insn[15:11]];
		c      = model_regs[rd];
		imm    = {{16{insn[15]}}, insn[15:0]};
		writes = (op >= 6'h01) && (op <= 6'h08);
		taken  = 1'b0;
		res    = '0;
		case (op)
			6'h01: res = a + b;
			6'h02: res = a - b;
			6'h03: res = a & b;
			6'h04: res = a | b;
			6'h05: res = a ^ b;
			6'h06: res = a << b[4:0];
			6'h07: res = a >> b[4:0];
			6'h08: res = a + imm;
			6'h10: taken = (a == c);
			6'h11: taken = (a != c);
			6'h12: taken = ($signed(a) < $signed(c));
			6'h3f: halt_seen = 1'b1;
			default: ;
		endcase
		if (writes) begin
			exp_q.push_back('{is_rdir: 1'b0, dst: rd, val: res});
			if (rd != '0) model_regs[rd] = res;	// r0 stays zero
		end
		if (taken) exp_q.push_back('{is_rdir: 1'b1, dst: '0, val: pc + imm});
		if (taken || op == 6'h3f) skip_next = 1'b1;
	endtask

	always @(posedge clk) begin
		if (!arst_n) begin
			foreach (model_regs[i]) model_regs[i] = '0;
			exp_q.delete();
			{skip_next, halt_seen, upd_prev, done} = '0;
			{wb_chk, wb_err, rd_chk, rd_err, dropped, halt_err, post_halt} = '0;
		end else if (!done) begin
			if (upd_prev && wb_out.valid) check_event(1'b0, wb_out.dst_addr, wb_out.data);
			if (upd_prev && redirect_out.valid) check_event(1'b1, '0, redirect_out.target);
			if (in_ready && skip_next) begin
				skip_next = 1'b0;	// branch or halt leaves EX at this edge
				if (fetch_in.valid) dropped++;
			end else if (fetch_in.valid && in_ready) begin
				if (halt_seen) begin
					$display("instruction accepted after HALT at pc %h", fetch_in.pc);
					halt_err++;
				end else begin
					run_model(fetch_in.pc, fetch_in.insn);
				end
			end
			upd_prev = !ex_hold;
			if (halted) begin
				if (!halt_seen) begin
					$display("halted went high before any HALT was accepted");
					halt_err++;
				end
				if (in_ready) begin
					$display("in_ready high while halted");
					halt_err++;
				end
				post_halt++;
				if (post_halt == 8) begin
					if (exp_q.size() != 0) begin
						$display("%0d expected results never appeared", exp_q.size());
						halt_err++;
					end
					$display("test writeback: %0d checked, %0d errors", wb_chk, wb_err);
					$display("test redirect: %0d checked, %0d errors", rd_chk, rd_err);
					$display("test flush: %0d squashed instructions", dropped);
					$display("test halt: %0d errors", halt_err);
					$display("checks %0d, errors %0d", wb_chk + rd_chk,
						wb_err + rd_err + halt_err);
					done = 1'b1;
				end
			end
		end
	end

endmodule

// File: testbench/tb_top.sv
//--------------------------------------
// testbench top: clock, reset, random program
// fetch model that follows redirects
//--------------------------------------
`timescale 1ns/1ns

module tb_top;
	import cpu_pkg::*;

	localparam int N_INSN      = 400;
	localparam int CYCLE_LIMIT = N_INSN * 4 + 100;

	logic      clk;
	logic      arst_n;
	fetch_t    fetch_in;
	logic      ex_hold;
	logic      in_ready;
	wb_t       wb_out;
	redirect_t redirect_out;
	logic      halted;
	word_t     prog [N_INSN];
	logic [31:0] rng;
	word_t     pc;
	logic      upd_prev;	// ex outputs updated at last edge
	int        cycles;
	int        errors;
	logic      done;

	function automatic logic [31:0] xorshift(logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic word_t enc(logic [5:0] op, reg_addr_t rd, reg_addr_t rs,
		logic [15:0] low);
		return {op, rd, rs, low};
	endfunction

	function automatic word_t insn_at(word_t addr);
		word_t idx;
		idx = addr >> 2;
		if (idx >= N_INSN - 1) begin
			return prog[N_INSN - 1];	// past the end reads halt
		end
		return prog[idx];
	endfunction

	//--------------------------------------
	// weighted random program, forward branches only
	//--------------------------------------
	task automatic build_program();
		logic [5:0] op;
		reg_addr_t  rd;
		reg_addr_t  rs;
		reg_addr_t  rt;
		int         pick;
		for (int i = 0; i < N_INSN - 1; i++) begin
			rng  = xorshift(rng);
			pick = rng % 100;
			rng  = xorshift(rng);
			rd   = 5'(rng[2:0]);			// r0..r7 for dense dependencies
			rs   = 5'(rng[10:8]);
			rt   = 5'(rng[18:16]);
			rng  = xorshift(rng);
			if (pick < 40) begin
				op      = 6'(1 + rng % 7);	// add .. srl
				prog[i] = enc(op, rd, rs, {rt, 11'b0});
			end else if (pick < 70) begin
				prog[i] = enc(OP_ADDI, rd, rs, rng[15:0]);
			end else if (pick < 88) begin
				op      = 6'(OP_BEQ + rng[1:0] % 3);
				prog[i] = enc(op, rd, rs, 16'(4 * (1 + rng[9:8])));
			end else if (pick < 95) begin
				prog[i] = enc(OP_NOP, rd, rs, rng[15:0]);
			end else begin
				prog[i] = enc(6'h20, rd, rs, rng[15:0]);	// unknown opcode
			end
		end
		prog[N_INSN - 1] = enc(OP_HALT, '0, '0, '0);
	endtask

	always #5 clk = ~clk;

	//--------------------------------------
	// fetch model and back-pressure
	//--------------------------------------
	always @(posedge clk) begin
		logic accepted;
		cycles <= cycles + 1;
		if (arst_n) begin
			accepted = fetch_in.valid && in_ready;
			if (redirect_out.valid && upd_prev) begin
				pc = redirect_out.target;
			end else if (accepted) begin
				pc = pc + 4;
			end
			upd_prev = !ex_hold;
			rng      = xorshift(rng);
			fetch_in <= '{valid: (rng[3:0] != 4'h0), pc: pc, insn: insn_at(pc)};
			rng      = xorshift(rng);
			ex_hold  <= (rng % 5) == 0;	// about 20%
		end
	end

	id_ex_core DUT (
		.clk          (clk),
		.arst_n       (arst_n),
		.fetch_in     (fetch_in),
		.ex_hold      (ex_hold),
		.in_ready     (in_ready),
		.wb_out       (wb_out),
		.redirect_out (redirect_out),
		.halted       (halted)
	);

	tb_checker u_checker (
		.clk          (clk),
		.arst_n       (arst_n),
		.fetch_in     (fetch_in),
		.ex_hold      (ex_hold),
		.in_ready     (in_ready),
		.wb_out       (wb_out),
		.redirect_out (redirect_out),
		.halted       (halted),
		.errors       (errors),
		.done         (done)
	);

	initial begin
		clk      = 1'b0;
		arst_n   = 1'b0;
		fetch_in = '0;
		ex_hold  = 1'b0;
		pc       = '0;
		rng      = 32'hade2_44c6;
		upd_prev = 1'b0;
		cycles   = 0;
		build_program();
		repeat (3) @(posedge clk);
		arst_n <= 1'b1;
		while (!done && cycles < CYCLE_LIMIT) @(negedge clk);
		if (!done) begin
			$display("timeout after %0d cycles, halt was never reached", cycles);
			$display("Errors found");
		end else if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

// File: list.f
design/cpu_pkg.sv
design/gpr_file.sv
design/decoder.sv
design/id_reg.sv
design/ex_unit.sv
design/pipe_ctrl.sv
design/id_ex_core.sv
testbench/tb_checker.sv
testbench/tb_top.sv

// File: run.sh
#!/bin/sh
# build and run the decode/execute testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_top -o tb_sim
./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Errors found" sim.log; then
	exit 1
fi
grep -q "No errors" sim.log
